/* sim.f */
+incdir+.
fp_div_pkg.sv
fp_unpack.sv
fp_div_core.sv
fp_round_pack.sv
fp_div_top.sv
fp_div_asserts.sv
fp_div_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fp_div_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* fp_div_tb.sv */
// ====================
// testbench for the binary32 divider
// vector table, clock and reset
// handshake and back-pressure checks
// ====================

`include "fp_div_config.svh"

module fp_div_tb;
    import fp_div_pkg::*;

    localparam int WAIT_LIMIT = 100;  // cycles per wait

    typedef struct packed {
        logic [`FP_WORD_W-1:0] a;
        logic [`FP_WORD_W-1:0] b;
        rnd_mode_e             rnd;
        logic [`FP_WORD_W-1:0] expect_res;
    } vec_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    rnd_mode_e             rnd;
    logic [`FP_WORD_W-1:0] in_1;
    logic [`FP_WORD_W-1:0] in_2;
    logic                  valid_ack;
    logic                  ready;
    logic                  valid;
    logic [`FP_WORD_W-1:0] res;

    vec_t   vectors[$];
    integer seed = 19;

    fp_div_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .rnd       (rnd),
        .in_1      (in_1),
        .in_2      (in_2),
        .ready     (ready),
        .valid     (valid),
        .res       (res),
        .valid_ack (valid_ack)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic add_vector(input logic [31:0] a, input logic [31:0] b,
                              input rnd_mode_e mode, input logic [31:0] expect_res);
        vec_t v;
        v.a          = a;
        v.b          = b;
        v.rnd        = mode;
        v.expect_res = expect_res;
        vectors.push_back(v);
    endtask

    task automatic load_vectors();
        add_vector(32'h40c0_0000, 32'h4000_0000, RNE, 32'h4040_0000);  // 6 / 2
        add_vector(32'hbf80_0000, 32'h3f00_0000, RNE, 32'hc000_0000);  // -1 / 0.5
        add_vector(32'h3f80_0000, 32'h3f80_0000, RNE, 32'h3f80_0000);
        // 1/3 in every mode
        add_vector(32'h3f80_0000, 32'h4040_0000, RNE, 32'h3eaa_aaab);
        add_vector(32'h3f80_0000, 32'h4040_0000, RTZ, 32'h3eaa_aaaa);
        add_vector(32'h3f80_0000, 32'h4040_0000, RDN, 32'h3eaa_aaaa);
        add_vector(32'h3f80_0000, 32'h4040_0000, RUP, 32'h3eaa_aaab);
        add_vector(32'h3f80_0000, 32'h4040_0000, RMM, 32'h3eaa_aaab);
        add_vector(32'hbf80_0000, 32'h4040_0000, RDN, 32'hbeaa_aaab);
        add_vector(32'hbf80_0000, 32'h4040_0000, RUP, 32'hbeaa_aaaa);
        // special operands
        add_vector(32'h3f80_0000, 32'h0000_0000, RNE, 32'h7f80_0000);
        add_vector(32'hbf80_0000, 32'h0000_0000, RNE, 32'hff80_0000);
        add_vector(32'h0000_0000, 32'h0000_0000, RNE, 32'h7fc0_0000);
        add_vector(32'h7f80_0000, 32'hff80_0000, RNE, 32'h7fc0_0000);
        add_vector(32'h7fa0_0000, 32'h3f80_0000, RNE, 32'h7fc0_0000);  // signaling NaN
        add_vector(32'h3f80_0000, 32'hffc0_0000, RNE, 32'h7fc0_0000);
        add_vector(32'h0000_0000, 32'h40a0_0000, RNE, 32'h0000_0000);
        add_vector(32'h3f80_0000, 32'h7f80_0000, RNE, 32'h0000_0000);
        add_vector(32'hbf80_0000, 32'h7f80_0000, RNE, 32'h8000_0000);
        add_vector(32'h0040_0000, 32'h3f80_0000, RNE, 32'h0000_0000);  // subnormal in
        // overflow and underflow
        add_vector(32'h7f7f_ffff, 32'h3f00_0000, RNE, 32'h7f80_0000);
        add_vector(32'h7f7f_ffff, 32'h3f00_0000, RTZ, 32'h7f7f_ffff);
        add_vector(32'hff7f_ffff, 32'h3f00_0000, RDN, 32'hff80_0000);
        add_vector(32'h0080_0000, 32'h7f00_0000, RNE, 32'h0000_0000);
        add_vector(32'h0080_0000, 32'h7f00_0000, RUP, 32'h0080_0000);
        add_vector(32'h8080_0000, 32'h7f00_0000, RUP, 32'h8000_0000);
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ready)
            report_failure("timeout: DUT never raised ready");
    endtask

    task automatic wait_for_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!valid)
            report_failure("timeout: DUT never presented a result");
    endtask

    task automatic issue_request(input vec_t v);
        @(posedge clk);
        in_1  <= v.a;
        in_2  <= v.b;
        rnd   <= v.rnd;
        start <= 1'b1;
        @(posedge clk);  // accepted here
        start <= 1'b0;
    endtask

    // keep valid_ack low for a random stretch, then acknowledge
    task automatic hold_and_ack(input logic [31:0] held, input bit poke_start);
        int hold;
        hold = 1 + ($unsigned($random(seed)) % 5);
        repeat (hold) begin
            @(posedge clk);
            if (poke_start) begin
                in_1  <= 32'h4120_0000;  // 10 / 2, must be dropped
                in_2  <= 32'h4000_0000;
                start <= 1'b1;
            end
            @(negedge clk);
            assert (valid === 1'b1)
                else report_failure($sformatf("MISMATCH valid: got %h, expected 1", valid));
            assert (ready === 1'b0)
                else report_failure($sformatf("MISMATCH ready: got %h, expected 0", ready));
            assert (res === held)
                else report_failure($sformatf("MISMATCH res: got %h, expected %h", res, held));
        end
        @(posedge clk);
        start     <= 1'b0;
        valid_ack <= 1'b1;
        @(posedge clk);
        valid_ack <= 1'b0;
        @(negedge clk);
        assert (valid === 1'b0)
            else report_failure($sformatf("MISMATCH valid: got %h, expected 0", valid));
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        rnd       = RNE;
        in_1      = '0;
        in_2      = '0;
        valid_ack = 1'b0;
        load_vectors();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (ready === 1'b1)
            else report_failure($sformatf("MISMATCH ready: got %h, expected 1", ready));
        assert (valid === 1'b0)
            else report_failure($sformatf("MISMATCH valid: got %h, expected 0", valid));

        for (int i = 0; i < vectors.size(); i++) begin
            wait_for_ready();
            issue_request(vectors[i]);
            wait_for_valid();
            assert (res === vectors[i].expect_res)
                else report_failure($sformatf("MISMATCH res: got %h, expected %h (vector %0d)",
                                              res, vectors[i].expect_res, i));
            // odd vectors also try a stray start
            hold_and_ack(vectors[i].expect_res, (i % 2) == 1);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* fp_div_asserts.sv */
// ====================
// handshake assertions for the divider top
// bound into fp_div_top
// ====================

`include "fp_div_config.svh"

module fp_div_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  ready,
    input logic                  valid,
    input logic [`FP_WORD_W-1:0] res,
    input logic                  valid_ack
);

    // result waits for the consumer
    valid_holds: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !valid_ack |=> valid)
        else $error("valid fell without valid_ack");

    // res frozen under back-pressure
    res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !valid_ack |=> $stable(res))
        else $error("res changed while waiting for valid_ack");

    // ready comes back on the ack edge and never alongside valid
    ack_hands_back: assert property (@(posedge clk) disable iff (!rst_n)
        valid && valid_ack |=> ready && !valid)
        else $error("ready did not take over from valid after valid_ack");

    // reset clears the output side
    reset_clears: assert property (@(posedge clk)
        !rst_n |=> !valid)
        else $error("valid high in the cycle after reset");

endmodule

bind fp_div_top fp_div_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready     (ready),
    .valid     (valid),
    .res       (res),
    .valid_ack (valid_ack)
);

/* fp_div_top.sv */
// ====================
// binary32 divider top
// unpack -> radix-4 core -> round/pack
// ====================

`include "fp_div_config.svh"

module fp_div_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  fp_div_pkg::rnd_mode_e  rnd,
    input  logic [`FP_WORD_W-1:0]  in_1,   // dividend
    input  logic [`FP_WORD_W-1:0]  in_2,   // divisor
    output logic                   ready,
    output logic                   valid,
    output logic [`FP_WORD_W-1:0]  res,
    input  logic                   valid_ack
);
    import fp_div_pkg::*;

    div_setup_t  setup;
    div_result_t qres;
    logic        done;

    fp_unpack u_unpack (
        .in_1  (in_1),
        .in_2  (in_2),
        .rnd   (rnd),
        .setup (setup)
    );

    // valid doubles as the busy flag back into the core
    fp_div_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .setup    (setup),
        .out_busy (valid),
        .ready    (ready),
        .done     (done),
        .qres     (qres)
    );

    fp_round_pack u_round_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .qres      (qres),
        .valid_ack (valid_ack),
        .valid     (valid),
        .res       (res)
    );

endmodule

/* fp_round_pack.sv */
// ====================
// normalize, round and pack the quotient
// overflow / underflow / special results
// result register and valid handshake
// ====================

`include "fp_div_config.svh"

module fp_round_pack (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    done,
    input  fp_div_pkg::div_result_t qres,
    input  logic                    valid_ack,
    output logic                    valid,
    output logic [`FP_WORD_W-1:0]   res
);
    import fp_div_pkg::*;

    localparam int QW      = `FP_QUOT_W;
    localparam int MW      = `FP_FRAC_W + 1;
    localparam int EXP_MAX = (1 << `FP_EXP_W) - 1;

    logic [MW-1:0]     mant;
    logic              guard;
    logic              rest;      // round and sticky together
    logic signed [9:0] exp_n;
    logic              inc;
    logic [MW:0]       mant_r;
    logic signed [9:0] exp_r;
    logic              ovf_inf;
    logic              dir_away;
    fp32_word_u        word;

    // one-bit normalize
    always_comb begin
        if (qres.quot[QW-1]) begin
            mant  = qres.quot[QW-1 -: MW];
            guard = qres.quot[QW-1-MW];
            rest  = |qres.quot[QW-2-MW:0];
            exp_n = qres.exp + 10'sd1;
        end else begin
            mant  = qres.quot[QW-2 -: MW];
            guard = qres.quot[QW-2-MW];
            rest  = |qres.quot[QW-3-MW:0];
            exp_n = qres.exp;
        end
    end

    // rounding increment
    always_comb begin
        case (qres.rnd)
            RNE:     inc = guard && (rest || mant[0]);
            RTZ:     inc = 1'b0;
            RDN:     inc = (guard || rest) && qres.sign;
            RUP:     inc = (guard || rest) && !qres.sign;
            RMM:     inc = guard;
            default: inc = 1'b0;
        endcase
    end

    assign mant_r = {1'b0, mant} + {{MW{1'b0}}, inc};
    assign exp_r  = exp_n + $signed({9'b0, mant_r[MW]});  // carry-out bumps exp

    // directed mode pointing away from zero
    assign dir_away = (qres.rnd == RUP && !qres.sign) || (qres.rnd == RDN && qres.sign);
    assign ovf_inf  = (qres.rnd == RNE) || (qres.rnd == RMM) || dir_away;

    always_comb begin
        word.bits   = '0;
        word.f.sign = qres.sign;
        case (qres.spc)
            SPC_NAN:  word.bits = `FP_QNAN;
            SPC_INF:  word.f.exp = '1;
            SPC_ZERO: word.f.exp = '0;
            default: begin
                if (exp_r >= $signed(10'(EXP_MAX))) begin
                    if (ovf_inf) begin
                        word.f.exp = '1;
                    end else begin
                        // largest finite
                        word.f.exp  = `FP_EXP_W'(EXP_MAX - 1);
                        word.f.frac = '1;
                    end
                end else if (exp_r <= 10'sd0) begin
                    if (dir_away)
                        word.f.exp = `FP_EXP_W'(1);  // smallest normal
                end else begin
                    word.f.exp  = exp_r[`FP_EXP_W-1:0];
                    word.f.frac = mant_r[`FP_FRAC_W-1:0];  // zero after carry
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (done) begin
            valid <= 1'b1;
        end else if (valid_ack) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done)
            res <= word.bits;  // held until the next result
    end

endmodule

/* fp_div_core.sv */
// ====================
// radix-4 restoring mantissa divider
// idle / dividing / finish FSM, request handshake
// ====================

`include "fp_div_config.svh"

module fp_div_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  fp_div_pkg::div_setup_t  setup,
    input  logic                    out_busy,
    output logic                    ready,
    output logic                    done,
    output fp_div_pkg::div_result_t qres
);
    import fp_div_pkg::*;

    localparam int MANT_W = `FP_FRAC_W + 1;
    localparam int REM_W  = MANT_W + 2;   // holds 4 * remainder
    localparam int CNT_W  = $clog2(`FP_DIV_STEPS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIV,
        S_FIN
    } state_e;

    state_e state_q;
    logic [CNT_W-1:0] cnt_q;

    logic [REM_W-1:0]      rem_q;
    logic [MANT_W-1:0]     dvsr_q;
    logic [REM_W-1:0]      dvsr3_q;
    logic [`FP_QUOT_W-1:0] quot_q;
    logic                  sign_q;
    special_e              spc_q;
    logic signed [9:0]     exp_q;
    rnd_mode_e             rnd_q;

    logic [REM_W:0]    diff3, diff2, diff1;  // msb is the borrow
    logic [1:0]        digit;
    logic [MANT_W-1:0] rem_next;
    logic              accept;

    assign ready  = (state_q == S_IDLE) && !out_busy;
    assign accept = start && ready;
    assign done   = (state_q == S_FIN);

    // trial subtractions of 3d, 2d and d
    assign diff3 = {1'b0, rem_q} - {1'b0, dvsr3_q};
    assign diff2 = {1'b0, rem_q} - {2'b00, dvsr_q, 1'b0};
    assign diff1 = {1'b0, rem_q} - {3'b000, dvsr_q};

    always_comb begin
        if (!diff3[REM_W]) begin
            digit    = 2'd3;
            rem_next = diff3[MANT_W-1:0];
        end else if (!diff2[REM_W]) begin
            digit    = 2'd2;
            rem_next = diff2[MANT_W-1:0];
        end else if (!diff1[REM_W]) begin
            digit    = 2'd1;
            rem_next = diff1[MANT_W-1:0];
        end else begin
            digit    = 2'd0;
            rem_next = rem_q[MANT_W-1:0];  // remainder already below d
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        cnt_q   <= CNT_W'(`FP_DIV_STEPS - 1);
                        state_q <= (setup.spc == SPC_NONE) ? S_DIV : S_FIN;
                    end
                end
                S_DIV: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0)
                        state_q <= S_FIN;
                end
                S_FIN: state_q <= S_IDLE;  // done pulse is one cycle
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q   <= {2'b00, setup.mant_a};
            dvsr_q  <= setup.mant_b;
            dvsr3_q <= {2'b00, setup.mant_b} + {1'b0, setup.mant_b, 1'b0};
            quot_q  <= '0;
            sign_q  <= setup.sign;
            spc_q   <= setup.spc;
            exp_q   <= setup.exp;
            rnd_q   <= setup.rnd;
        end else if (state_q == S_DIV) begin
            quot_q <= {quot_q[`FP_QUOT_W-3:0], digit};
            rem_q  <= {rem_next, 2'b00};
        end
    end

    always_comb begin
        qres.sign = sign_q;
        qres.spc  = spc_q;
        qres.exp  = exp_q;
        qres.quot = {quot_q[`FP_QUOT_W-1:1], quot_q[0] | (|rem_q)};  // fold in sticky
        qres.rnd  = rnd_q;
    end

endmodule

/* fp_unpack.sv */
// ====================
// operand classification for the divider
// picks the special class, sign and exponent estimate
// ====================

`include "fp_div_config.svh"

module fp_unpack (
    input  logic [`FP_WORD_W-1:0]  in_1,
    input  logic [`FP_WORD_W-1:0]  in_2,
    input  fp_div_pkg::rnd_mode_e  rnd,
    output fp_div_pkg::div_setup_t setup
);
    import fp_div_pkg::*;

    fp32_word_u op_a;
    fp32_word_u op_b;

    logic nan_a, nan_b;
    logic inf_a, inf_b;
    logic zero_a, zero_b;

    assign op_a.bits = in_1;
    assign op_b.bits = in_2;

    // all-ones exponent is inf or NaN
    assign nan_a  = (&op_a.f.exp) && (op_a.f.frac != '0);
    assign nan_b  = (&op_b.f.exp) && (op_b.f.frac != '0);
    assign inf_a  = (&op_a.f.exp) && (op_a.f.frac == '0);
    assign inf_b  = (&op_b.f.exp) && (op_b.f.frac == '0);
    assign zero_a = (op_a.f.exp == '0);  // subnormals count as zero
    assign zero_b = (op_b.f.exp == '0);

    always_comb begin
        setup.sign = op_a.f.sign ^ op_b.f.sign;

        if (nan_a || nan_b || (zero_a && zero_b) || (inf_a && inf_b)) begin
            setup.spc = SPC_NAN;
        end else if (inf_a || zero_b) begin
            setup.spc = SPC_INF;
        end else if (zero_a || inf_b) begin
            setup.spc = SPC_ZERO;
        end else begin
            setup.spc = SPC_NONE;
        end

        // ea - eb + bias - 1, bumped later if a >= b
        setup.exp = $signed({2'b00, op_a.f.exp}) - $signed({2'b00, op_b.f.exp})
                    + $signed(10'(`FP_BIAS - 1));

        setup.mant_a = {1'b1, op_a.f.frac};
        setup.mant_b = {1'b1, op_b.f.frac};
        setup.rnd    = rnd;
    end

endmodule

/* fp_div_pkg.sv */
// ====================
// shared types of the divider
// binary32 word view, rounding modes, special classes
// setup and result structs passed between stages
// ====================

`include "fp_div_config.svh"

package fp_div_pkg;

    // field view of a binary32 word
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_fields_t;

    // one word, read either as raw bits or as fields
    typedef union packed {
        logic [`FP_WORD_W-1:0] bits;
        fp32_fields_t          f;
    } fp32_word_u;

    typedef enum logic [2:0] {
        RNE = 3'd0,  // nearest, ties to even
        RTZ = 3'd1,  // toward zero
        RDN = 3'd2,  // toward -inf
        RUP = 3'd3,  // toward +inf
        RMM = 3'd4   // nearest, ties away
    } rnd_mode_e;

    typedef enum logic [1:0] {
        SPC_NONE,
        SPC_NAN,
        SPC_INF,
        SPC_ZERO
    } special_e;

    // unpack -> core
    typedef struct packed {
        logic                 sign;
        special_e             spc;
        logic signed [9:0]    exp;     // biased, assumes quotient < 1
        logic [`FP_FRAC_W:0]  mant_a;  // dividend with hidden bit
        logic [`FP_FRAC_W:0]  mant_b;  // divisor with hidden bit
        rnd_mode_e            rnd;
    } div_setup_t;

    // core -> round/pack
    typedef struct packed {
        logic                  sign;
        special_e              spc;
        logic signed [9:0]     exp;
        logic [`FP_QUOT_W-1:0] quot;   // bit 0 carries the sticky
        rnd_mode_e             rnd;
    } div_result_t;

endpackage

/* fp_div_config.svh */
// ====================
// binary32 format widths and bias
// radix-4 divider step count
// canonical quiet NaN
// ====================

`ifndef FP_DIV_CONFIG_SVH
`define FP_DIV_CONFIG_SVH

// binary32 fields
`define FP_EXP_W      8
`define FP_FRAC_W     23
`define FP_BIAS       127
`define FP_WORD_W     32

// 1 integer + 23 fraction + guard, round, sticky
`define FP_QUOT_W     27

// two quotient bits per step, 28 raw bits
`define FP_DIV_STEPS  14

`define FP_QNAN       32'h7fc0_0000

`endif
